// ==== build.f ====
design/mpmem_pkg.sv
design/mpmem_sram_1r1w.sv
design/mpmem_wr_decode.sv
design/mpmem_bank_array.sv
design/mpmem_lvt.sv
design/mpmem_rd_result.sv
design/mpmem_top.sv
dv/tb_clkgen.sv
dv/mpmem_tb.sv

// ==== design/mpmem_bank_array.sv ====
`timescale 1ns/100ps

module mpmem_bank_array
  import mpmem_pkg::*;
#(
  parameter int NUMWRPT = 2,
  parameter int NUMRDPT = 3
) (
  input  logic                                   clk,
  input  wr_req_t [NUMWRPT-1:0]                  wr_dec,
  input  rd_req_t [NUMRDPT-1:0]                  rd_q,
  output logic [NUMRDPT-1:0][NUMWRPT-1:0][WIDTH-1:0] bank_dout
);

  logic [NUMWRPT-1:0]              bank_we;
  logic [NUMWRPT-1:0][BITADDR-1:0] bank_waddr;
  logic [NUMWRPT-1:0][WIDTH-1:0]   bank_wdata;
  logic [NUMRDPT-1:0][BITADDR-1:0] bank_raddr;

  // each write port owns one column of banks.
  always_comb begin
    for (int w = 0; w < NUMWRPT; w++) begin
      bank_we[w]    = wr_dec[w].valid;
      bank_waddr[w] = wr_dec[w].addr;
      bank_wdata[w] = wr_dec[w].data;
    end
  end

  // each read port owns one row of banks.
  always_comb begin
    for (int r = 0; r < NUMRDPT; r++) begin
      bank_raddr[r] = rd_q[r].addr;
    end
  end

  for (genvar w = 0; w < NUMWRPT; w++) begin : g_col
    for (genvar r = 0; r < NUMRDPT; r++) begin : g_row
      mpmem_sram_1r1w u_sram (
        .clk   (clk),
        .we    (bank_we[w]),
        .waddr (bank_waddr[w]),
        .wdata (bank_wdata[w]),
        .raddr (bank_raddr[r]),
        .rdata (bank_dout[r][w])
      );
    end
  end

endmodule

// ==== design/mpmem_lvt.sv ====
`timescale 1ns/100ps

module mpmem_lvt
  import mpmem_pkg::*;
#(
  parameter int NUMWRPT = 2,
  parameter int NUMRDPT = 3
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  wr_req_t [NUMWRPT-1:0]            wr_dec,
  input  rd_req_t [NUMRDPT-1:0]            rd_q,
  output logic [NUMRDPT-1:0][BITWRPT-1:0]  lvt_sel
);

  // last writer of each address.
  logic [BITWRPT-1:0] lvt_mem [NUMADDR];

  // collisions are already resolved, so at most one port per address.
  always_ff @(posedge clk) begin
    for (int w = 0; w < NUMWRPT; w++) begin
      if (wr_dec[w].valid) begin
        lvt_mem[wr_dec[w].addr] <= BITWRPT'(w);
      end
    end
  end

  // registered lookup lines up with the bank read data.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lvt_sel <= '0;
    end else begin
      for (int r = 0; r < NUMRDPT; r++) begin
        lvt_sel[r] <= lvt_mem[rd_q[r].addr];
      end
    end
  end

endmodule

// ==== design/mpmem_pkg.sv ====
package mpmem_pkg;

  // data word width.
  parameter int WIDTH = 32;

  // 64 words.
  parameter int BITADDR = 6;
  parameter int NUMADDR = 1 << BITADDR;

  // index of a write port, so up to four write ports.
  parameter int BITWRPT = 2;

  // one write port request.
  typedef struct packed {
    logic               valid;
    logic [BITADDR-1:0] addr;
    logic [WIDTH-1:0]   data;
  } wr_req_t;

  // one read port request.
  typedef struct packed {
    logic               valid;
    logic [BITADDR-1:0] addr;
  } rd_req_t;

  // one read port response.
  typedef struct packed {
    logic             vld;
    logic [WIDTH-1:0] data;
  } rd_rsp_t;

endpackage

// ==== design/mpmem_rd_result.sv ====
`timescale 1ns/100ps

module mpmem_rd_result
  import mpmem_pkg::*;
#(
  parameter int NUMWRPT = 2,
  parameter int NUMRDPT = 3
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       ready,
  input  rd_req_t [NUMRDPT-1:0]                      rd,
  output rd_req_t [NUMRDPT-1:0]                      rd_q,
  input  logic [NUMRDPT-1:0][NUMWRPT-1:0][WIDTH-1:0] bank_dout,
  input  logic [NUMRDPT-1:0][BITWRPT-1:0]            lvt_sel,
  output rd_rsp_t [NUMRDPT-1:0]                      rsp
);

  logic [NUMRDPT-1:0]              q_vld;
  logic [NUMRDPT-1:0][BITADDR-1:0] q_addr;
  logic [NUMRDPT-1:0]              vld_d1;
  logic [NUMRDPT-1:0]              rsp_vld;
  logic [NUMRDPT-1:0][WIDTH-1:0]   rsp_data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      q_vld   <= '0;
      vld_d1  <= '0;
      rsp_vld <= '0;
    end else begin
      for (int r = 0; r < NUMRDPT; r++) begin
        q_vld[r] <= rd[r].valid && ready;  // drop reads until init is done.
      end
      vld_d1  <= q_vld;
      rsp_vld <= vld_d1;
    end
  end

  always_ff @(posedge clk) begin
    for (int r = 0; r < NUMRDPT; r++) begin
      q_addr[r]   <= rd[r].addr;
      rsp_data[r] <= bank_dout[r][lvt_sel[r]];  // newest copy per lvt.
    end
  end

  always_comb begin
    for (int r = 0; r < NUMRDPT; r++) begin
      rd_q[r].valid = q_vld[r];
      rd_q[r].addr  = q_addr[r];
      rsp[r].vld    = rsp_vld[r];
      rsp[r].data   = rsp_data[r];
    end
  end

endmodule

// ==== design/mpmem_sram_1r1w.sv ====
`timescale 1ns/100ps

module mpmem_sram_1r1w
  import mpmem_pkg::*;
(
  input  logic               clk,
  input  logic               we,
  input  logic [BITADDR-1:0] waddr,
  input  logic [WIDTH-1:0]   wdata,
  input  logic [BITADDR-1:0] raddr,
  output logic [WIDTH-1:0]   rdata
);

  logic [WIDTH-1:0] mem [NUMADDR];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // read before write on a shared address.
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

// ==== design/mpmem_top.sv ====
`timescale 1ns/100ps

module mpmem_top
  import mpmem_pkg::*;
#(
  parameter int NUMWRPT = 2,
  parameter int NUMRDPT = 3
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  wr_req_t [NUMWRPT-1:0] wr,
  input  rd_req_t [NUMRDPT-1:0] rd,
  output rd_rsp_t [NUMRDPT-1:0] rsp,
  output logic                  ready
);

  logic                                       rst_q;
  logic                                       rst_int_n;
  wr_req_t [NUMWRPT-1:0]                      wr_dec;
  rd_req_t [NUMRDPT-1:0]                      rd_q;
  logic [NUMRDPT-1:0][NUMWRPT-1:0][WIDTH-1:0] bank_dout;
  logic [NUMRDPT-1:0][BITWRPT-1:0]            lvt_sel;

  // hold reset one extra cycle.
  always_ff @(posedge clk) begin
    rst_q <= rst_n;
  end

  assign rst_int_n = rst_q && rst_n;

  mpmem_wr_decode #(.NUMWRPT(NUMWRPT)) u_wr_decode (
    .clk    (clk),
    .rst_n  (rst_int_n),
    .wr     (wr),
    .wr_dec (wr_dec),
    .ready  (ready)
  );

  mpmem_bank_array #(.NUMWRPT(NUMWRPT), .NUMRDPT(NUMRDPT)) u_bank_array (
    .clk       (clk),
    .wr_dec    (wr_dec),
    .rd_q      (rd_q),
    .bank_dout (bank_dout)
  );

  mpmem_lvt #(.NUMWRPT(NUMWRPT), .NUMRDPT(NUMRDPT)) u_lvt (
    .clk     (clk),
    .rst_n   (rst_int_n),
    .wr_dec  (wr_dec),
    .rd_q    (rd_q),
    .lvt_sel (lvt_sel)
  );

  mpmem_rd_result #(.NUMWRPT(NUMWRPT), .NUMRDPT(NUMRDPT)) u_rd_result (
    .clk       (clk),
    .rst_n     (rst_int_n),
    .ready     (ready),
    .rd        (rd),
    .rd_q      (rd_q),
    .bank_dout (bank_dout),
    .lvt_sel   (lvt_sel),
    .rsp       (rsp)
  );

endmodule

// ==== design/mpmem_wr_decode.sv ====
`timescale 1ns/100ps

module mpmem_wr_decode
  import mpmem_pkg::*;
#(
  parameter int NUMWRPT = 2
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  wr_req_t [NUMWRPT-1:0]     wr,
  output wr_req_t [NUMWRPT-1:0]     wr_dec,
  output logic                      ready
);

  logic [BITADDR-1:0]              init_addr;
  logic [NUMWRPT-1:0]              win;
  logic [NUMWRPT-1:0]              dec_vld;
  logic [NUMWRPT-1:0][BITADDR-1:0] dec_addr;
  logic [NUMWRPT-1:0][WIDTH-1:0]   dec_data;

  // a higher numbered port on the same address wins.
  always_comb begin
    for (int i = 0; i < NUMWRPT; i++) begin
      win[i] = wr[i].valid;
      for (int j = i + 1; j < NUMWRPT; j++) begin
        if (wr[j].valid && (wr[j].addr == wr[i].addr)) begin
          win[i] = 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ready     <= 1'b0;
      init_addr <= '0;
      dec_vld   <= '0;
    end else if (!ready) begin
      init_addr <= init_addr + 1'b1;  // sweep port 0 over every address.
      dec_vld   <= NUMWRPT'(1);
      if (init_addr == '1) begin
        ready <= 1'b1;
      end
    end else begin
      dec_vld <= win;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUMWRPT; i++) begin
      if (!ready && (i == 0)) begin
        dec_addr[i] <= init_addr;
        dec_data[i] <= '0;  // init clears column 0.
      end else begin
        dec_addr[i] <= wr[i].addr;
        dec_data[i] <= wr[i].data;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUMWRPT; i++) begin
      wr_dec[i].valid = dec_vld[i];
      wr_dec[i].addr  = dec_addr[i];
      wr_dec[i].data  = dec_data[i];
    end
  end

endmodule

// ==== dv/mpmem_tb.sv ====
`timescale 1ns/100ps

module mpmem_tb
  import mpmem_pkg::*;
();

  localparam int NUMWRPT       = 2;
  localparam int NUMRDPT       = 3;
  localparam int READY_TIMEOUT = 100;
  localparam int DRAIN_TIMEOUT = 10;
  localparam int MIX_CYCLES    = 2000;

  logic                  clk;
  logic                  rst_n;
  wr_req_t [NUMWRPT-1:0] wr;
  rd_req_t [NUMRDPT-1:0] rd;
  rd_rsp_t [NUMRDPT-1:0] rsp;
  logic                  ready;

  wr_req_t [NUMWRPT-1:0] wr_nxt;
  rd_req_t [NUMRDPT-1:0] rd_nxt;

  logic [WIDTH-1:0]   model_mem [NUMADDR];
  // stage 0 is driven but not yet sampled, stage 2 is due on rsp now.
  logic               exp_vld  [NUMRDPT][3];
  logic [WIDTH-1:0]   exp_data [NUMRDPT][3];
  logic [BITADDR-1:0] exp_addr [NUMRDPT][3];

  logic [31:0] rng_state;
  string       test_name;
  int          value_errs;
  int          other_errs;
  int          pending;
  bit          mon_en;
  bit          ready_seen;
  bit          timed_out;

  tb_clkgen #(.RST_CYCLES(2)) u_clkgen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  mpmem_top #(.NUMWRPT(NUMWRPT), .NUMRDPT(NUMRDPT)) uut (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (wr),
    .rd    (rd),
    .rsp   (rsp),
    .ready (ready)
  );

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // outputs are compared at the falling edge, midway between updates.
  always @(negedge clk) begin
    if (mon_en) begin
      if (ready) begin
        ready_seen = 1'b1;
      end else if (ready_seen) begin
        other_errs++;
        $display("ready dropped after init at %0t", $time);
      end
      for (int r = 0; r < NUMRDPT; r++) begin
        if (rsp[r].vld !== exp_vld[r][2]) begin
          other_errs++;
          if (exp_vld[r][2]) begin
            $display("%s: missing rsp vld on port %0d at %0t", test_name, r, $time);
          end else begin
            $display("%s: extra rsp vld on port %0d at %0t", test_name, r, $time);
          end
        end else if (exp_vld[r][2] && (rsp[r].data !== exp_data[r][2])) begin
          value_errs++;
          $display("FAILED %s port %0d addr %0d: expected %h actual %h", test_name, r,
                   exp_addr[r][2], exp_data[r][2], rsp[r].data);
        end
        exp_vld[r][2]  = exp_vld[r][1];
        exp_data[r][2] = exp_data[r][1];
        exp_addr[r][2] = exp_addr[r][1];
        exp_vld[r][1]  = exp_vld[r][0];
        exp_data[r][1] = exp_data[r][0];
        exp_addr[r][1] = exp_addr[r][0];
        exp_vld[r][0]  = ready && rd[r].valid;
        exp_data[r][0] = model_mem[rd[r].addr];  // reads see memory before this edge's writes.
        exp_addr[r][0] = rd[r].addr;
      end
      if (ready) begin
        for (int w = 0; w < NUMWRPT; w++) begin
          if (wr[w].valid) begin
            model_mem[wr[w].addr] = wr[w].data;  // ascending order, highest port wins.
          end
        end
      end
      pending = 0;
      for (int r = 0; r < NUMRDPT; r++) begin
        for (int s = 0; s < 3; s++) begin
          if (exp_vld[r][s]) begin
            pending++;
          end
        end
        if (rsp[r].vld !== 1'b0) begin
          pending++;  // a response still on the port keeps the drain waiting.
        end
      end
    end
  end

  task automatic clear_nxt();
    wr_nxt = '0;
    rd_nxt = '0;
  endtask

  task automatic step();
    @(posedge clk);
    wr <= wr_nxt;
    rd <= rd_nxt;
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!ready && (n < READY_TIMEOUT)) begin
      @(negedge clk);
      n++;
    end
    if (!ready) begin
      other_errs++;
      timed_out = 1'b1;
      $display("timeout: ready did not rise within %0d cycles", READY_TIMEOUT);
    end
  endtask

  task automatic drain();
    int n;
    clear_nxt();
    step();
    n = 0;
    while ((pending != 0) && (n < DRAIN_TIMEOUT)) begin
      @(posedge clk);
      n++;
    end
    if (pending != 0) begin
      other_errs++;
      timed_out = 1'b1;
      $display("timeout: read responses still active after %0d cycles in %s",
               DRAIN_TIMEOUT, test_name);
    end
  endtask

  task automatic check_reset();
    test_name = "reset";
    @(posedge clk);
    mon_en = 1'b1;
    @(negedge clk);
    if (ready !== 1'b0) begin
      other_errs++;
      $display("ready is high during reset");
    end
    for (int r = 0; r < NUMRDPT; r++) begin
      if (rsp[r].vld !== 1'b0) begin
        other_errs++;
        $display("rsp vld is high on port %0d during reset", r);
      end
    end
    wait_ready();
  endtask

  task automatic test_unwritten();
    test_name = "unwritten";
    clear_nxt();
    for (int a = 0; a < NUMADDR; a++) begin
      for (int r = 0; r < NUMRDPT; r++) begin
        rd_nxt[r].valid = 1'b1;
        rd_nxt[r].addr  = BITADDR'(a + r);  // each port walks its own offset.
      end
      step();
    end
    drain();
  endtask

  task automatic test_random_rw();
    test_name = "random_rw";
    clear_nxt();
    for (int i = 0; i < NUMADDR; i++) begin
      for (int w = 0; w < NUMWRPT; w++) begin
        wr_nxt[w].valid = 1'b1;
        wr_nxt[w].addr  = BITADDR'(next_rand());
        wr_nxt[w].data  = next_rand();
      end
      step();
    end
    clear_nxt();
    for (int i = 0; i < NUMADDR; i++) begin
      for (int r = 0; r < NUMRDPT; r++) begin
        rd_nxt[r].valid = 1'b1;
        rd_nxt[r].addr  = BITADDR'(next_rand());
      end
      step();
    end
    drain();
  endtask

  task automatic test_collision();
    logic [BITADDR-1:0] addr;
    test_name = "collision";
    for (int i = 0; i < 32; i++) begin
      addr = BITADDR'(next_rand());
      clear_nxt();
      for (int w = 0; w < NUMWRPT; w++) begin
        wr_nxt[w].valid = 1'b1;
        wr_nxt[w].addr  = addr;
        wr_nxt[w].data  = next_rand();
      end
      step();
      clear_nxt();
      for (int r = 0; r < NUMRDPT; r++) begin
        rd_nxt[r].valid = 1'b1;
        rd_nxt[r].addr  = addr;
      end
      step();
    end
    drain();
  endtask

  task automatic test_same_cycle();
    logic [BITADDR-1:0] addr;
    int                 w;
    test_name = "same_cycle";
    for (int i = 0; i < 16; i++) begin
      addr = BITADDR'(next_rand());
      w    = int'(next_rand() % NUMWRPT);
      clear_nxt();
      wr_nxt[w].valid = 1'b1;
      wr_nxt[w].addr  = addr;
      wr_nxt[w].data  = next_rand();
      step();
      clear_nxt();
      wr_nxt[(w + 1) % NUMWRPT].valid = 1'b1;
      wr_nxt[(w + 1) % NUMWRPT].addr  = addr;
      wr_nxt[(w + 1) % NUMWRPT].data  = next_rand();
      for (int r = 0; r < NUMRDPT; r++) begin
        rd_nxt[r].valid = 1'b1;
        rd_nxt[r].addr  = addr;
      end
      step();
      wr_nxt = '0;  // same reads again, now after the write.
      step();
    end
    drain();
  endtask

  task automatic test_mixed();
    logic [31:0] rv;
    test_name = "mixed";
    for (int i = 0; i < MIX_CYCLES; i++) begin
      for (int w = 0; w < NUMWRPT; w++) begin
        rv = next_rand();
        wr_nxt[w].valid = rv[0];
        wr_nxt[w].addr  = BITADDR'(rv[15:8] & (rv[4] ? 8'hff : 8'h07));  // narrow range collides.
        wr_nxt[w].data  = next_rand();
      end
      for (int r = 0; r < NUMRDPT; r++) begin
        rv = next_rand();
        rd_nxt[r].valid = (rv[2:1] != 2'b00);
        rd_nxt[r].addr  = BITADDR'(rv[15:8] & (rv[4] ? 8'hff : 8'h07));
      end
      step();
    end
    drain();
  endtask

  initial begin
    wr        = '0;
    rd        = '0;
    wr_nxt    = '0;
    rd_nxt    = '0;
    rng_state = 32'd69022;
    test_name = "init";
    for (int a = 0; a < NUMADDR; a++) begin
      model_mem[a] = '0;
    end
    for (int r = 0; r < NUMRDPT; r++) begin
      for (int s = 0; s < 3; s++) begin
        exp_vld[r][s]  = 1'b0;
        exp_data[r][s] = '0;
        exp_addr[r][s] = '0;
      end
    end
    check_reset();
    if (!timed_out) test_unwritten();
    if (!timed_out) test_random_rw();
    if (!timed_out) test_collision();
    if (!timed_out) test_same_cycle();
    if (!timed_out) test_mixed();
    $display("errors: %0d wrong values, %0d other", value_errs, other_errs);
    if ((value_errs == 0) && (other_errs == 0)) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== dv/tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen #(
  parameter int RST_CYCLES = 2
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period.
  end

  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

log=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module mpmem_tb \
  -f build.f -o mpmem_sim

./obj_dir/mpmem_sim | tee "$log"

if grep -q "Simulation failed" "$log"; then
  echo "testbench reported errors, see $log"
  exit 1
fi

echo "run finished without reported errors"
